// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = uart_ctl_sys_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed
PASS_MSG  = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; \
	else echo "Result: PASS"; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
logic/uart_ctl_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_engine.sv
logic/uart_ctl_sys.sv
tb/uart_ctl_sys_tb.sv

// ==== logic/cmd_engine.sv ====
// Command decoder for the serial control link
// LED register, switch synchronizer and reply generation

`timescale 1ns/1ps

module cmd_engine (
	input  logic                   clk,
	input  logic                   i_reset,
	input  uart_ctl_pkg::rx_beat_t i_beat,
	input  logic [3:0]             i_sw,
	output logic [3:0]             o_led,
	output logic                   o_tx_strobe,
	output logic [7:0]             o_tx_data
);

	logic [3:0] sw_meta;
	logic [3:0] sw_sync;
	logic [3:0] led_q;
	logic       tx_strobe_q;
	logic [7:0] tx_data_q;

	// Switches are asynchronous to clk
	always_ff @(posedge clk) begin
		if (i_reset) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= i_sw;
			sw_sync <= sw_meta;
		end
	end

	// LED register and reply strobe
	always_ff @(posedge clk) begin
		if (i_reset) begin
			led_q       <= '0;
			tx_strobe_q <= 1'b0;
		end else begin
			tx_strobe_q <= 1'b0;
			if (i_beat.strobe) begin
				case (i_beat.data.op)
					uart_ctl_pkg::OP_SET_LED: begin
						led_q <= i_beat.data.arg;
					end
					default: begin
						// Every other opcode answers with one byte
						tx_strobe_q <= 1'b1;
					end
				endcase
			end
		end
	end

	// Reply payload, only meaningful alongside the strobe
	always_ff @(posedge clk) begin
		if (i_beat.strobe) begin
			case (i_beat.data.op)
				uart_ctl_pkg::OP_GET_SW: begin
					tx_data_q <= {uart_ctl_pkg::REPLY_SW, sw_sync};
				end
				uart_ctl_pkg::OP_GET_LED: begin
					tx_data_q <= {uart_ctl_pkg::REPLY_LED, led_q};
				end
				default: begin
					tx_data_q <= uart_ctl_pkg::REPLY_ERR;
				end
			endcase
		end
	end

	assign o_led       = led_q;
	assign o_tx_strobe = tx_strobe_q;
	assign o_tx_data   = tx_data_q;

	// A reply always answers the byte received the cycle before
	a_reply_follows_cmd: assert property (@(posedge clk) disable iff (i_reset)
		o_tx_strobe |-> $past(i_beat.strobe));

endmodule

// ==== logic/uart_ctl_pkg.sv ====
// Shared definitions for the serial control subsystem
// Command opcodes, command byte layout, received-byte beat and reply prefixes

package uart_ctl_pkg;

	// Opcode lives in the top two bits of every command byte
	typedef enum logic [1:0] {
		OP_SET_LED = 2'd0,
		OP_GET_SW  = 2'd1,
		OP_GET_LED = 2'd2,
		OP_BAD     = 2'd3
	} cmd_op_e;

	// Command byte as sent by the host
	typedef struct packed {
		cmd_op_e    op;
		logic [1:0] rsvd;
		logic [3:0] arg;
	} cmd_byte_t;

	// One received byte, data valid while strobe is high
	typedef struct packed {
		logic      strobe;
		cmd_byte_t data;
	} rx_beat_t;

	// Upper nibble of a switch reply
	parameter logic [3:0] REPLY_SW = 4'h5;

	// Upper nibble of an LED reply
	parameter logic [3:0] REPLY_LED = 4'hA;

	// Whole reply byte for an unknown opcode
	parameter logic [7:0] REPLY_ERR = 8'hEE;

endpackage

// ==== logic/uart_ctl_sys.sv ====
// Top level of the serial control subsystem
// Derives the UART bit length and connects receiver, command engine, transmitter

`timescale 1ns/1ps

module uart_ctl_sys #(
	parameter int CLK_PERIOD = 4,
	parameter int UART_BAUD  = 12500000
) (
	input  logic       clk,
	input  logic       i_reset,
	input  logic       i_uart_rx,
	input  logic [3:0] i_sw,
	output logic       o_uart_tx,
	output logic [3:0] o_led
);

	// Clock period is in ns, so one second is 1e9 of it
	localparam logic [15:0] CLKS_PER_BIT = 16'(1000000000 / (CLK_PERIOD * UART_BAUD));

	if (CLKS_PER_BIT < 16'd4) begin : g_bit_len_check
		$error("UART bit length of %0d clocks is too short", CLKS_PER_BIT);
	end

	uart_ctl_pkg::rx_beat_t rx_beat;
	logic                   tx_strobe;
	logic [7:0]             tx_data;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_i (
		.clk     (clk),
		.i_reset (i_reset),
		.i_rx    (i_uart_rx),
		.o_beat  (rx_beat)
	);

	cmd_engine cmd_i (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_beat      (rx_beat),
		.i_sw        (i_sw),
		.o_led       (o_led),
		.o_tx_strobe (tx_strobe),
		.o_tx_data   (tx_data)
	);

	// A command takes a whole frame to arrive, which keeps replies from overlapping
	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_i (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_strobe (tx_strobe),
		.i_data   (tx_data),
		.o_tx     (o_uart_tx),
		.o_busy   ()
	);

endmodule

// ==== logic/uart_rx.sv ====
// UART receiver, 8 data bits, no parity, one stop bit
// Falling-edge start detection, mid-bit sampling, stop-bit check

`timescale 1ns/1ps

module uart_rx #(
	parameter logic [15:0] CLKS_PER_BIT = 16'd20
) (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_rx,
	output uart_ctl_pkg::rx_beat_t o_beat
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e   state;
	logic        rx_meta;
	logic        rx_sync;
	logic        rx_prev;
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  shreg;
	logic        strobe_q;

	// Line synchronizer plus one extra flop for edge detection
	always_ff @(posedge clk) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state    <= RX_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= 1'b0;
			cnt      <= cnt + 16'd1;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					// Only a real high-to-low transition starts a frame
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (cnt == (CLKS_PER_BIT >> 1) - 16'd1) begin
						cnt     <= '0;
						bit_idx <= '0;
						// Line back high at mid-bit means it was a glitch
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (cnt == CLKS_PER_BIT - 16'd1) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				default: begin
					if (cnt == CLKS_PER_BIT - 16'd1) begin
						strobe_q <= rx_sync;
						state    <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && cnt == CLKS_PER_BIT - 16'd1)
			shreg <= {rx_sync, shreg[7:1]};
	end

	// Shift register holds still outside RX_DATA, so it is valid with the strobe
	assign o_beat.strobe = strobe_q;
	assign o_beat.data   = uart_ctl_pkg::cmd_byte_t'(shreg);

	a_strobe_single: assert property (@(posedge clk) disable iff (i_reset)
		o_beat.strobe |=> !o_beat.strobe);

endmodule

// ==== logic/uart_tx.sv ====
// UART transmitter, one 10-bit frame per input strobe
// LSB first, line idles high

`timescale 1ns/1ps

module uart_tx #(
	parameter logic [15:0] CLKS_PER_BIT = 16'd20
) (
	input  logic       clk,
	input  logic       i_reset,
	input  logic       i_strobe,
	input  logic [7:0] i_data,
	output logic       o_tx,
	output logic       o_busy
);

	logic [9:0]  shreg;
	logic [15:0] cnt;
	logic [3:0]  bit_idx;
	logic        busy_q;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			shreg   <= '1;
			cnt     <= '0;
			bit_idx <= '0;
			busy_q  <= 1'b0;
		end else if (i_strobe) begin
			// Stop, data, start; bit 0 drives the line from the next cycle
			shreg   <= {1'b1, i_data, 1'b0};
			cnt     <= '0;
			bit_idx <= '0;
			busy_q  <= 1'b1;
		end else if (busy_q) begin
			if (cnt == CLKS_PER_BIT - 16'd1) begin
				cnt     <= '0;
				shreg   <= {1'b1, shreg[9:1]};
				bit_idx <= bit_idx + 4'd1;
			end else begin
				cnt <= cnt + 16'd1;
			end
			// Release busy one cycle before the stop bit ends.
			// A strobe on the last stop cycle then starts the next frame on time.
			if (bit_idx == 4'd9 && cnt == CLKS_PER_BIT - 16'd2)
				busy_q <= 1'b0;
		end
	end

	// Stop bit and idle are both high, so the line simply stays at shreg[0]
	assign o_tx   = shreg[0];
	assign o_busy = busy_q;

	a_no_strobe_busy: assert property (@(posedge clk) disable iff (i_reset)
		i_strobe |-> !o_busy);

endmodule

// ==== tb/uart_ctl_sys_tb.sv ====
// Testbench for the serial control subsystem
// Clock, reset, host UART model, reply monitor, directed tests and watchdog

`timescale 1ns/1ps

module uart_ctl_sys_tb;

	localparam int CLK_PERIOD   = 4;
	localparam int UART_BAUD    = 12500000;
	localparam int CLKS_PER_BIT = 1000000000 / (CLK_PERIOD * UART_BAUD);
	localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
	// 40 frames of run time plus 2 us of margin
	localparam int WATCHDOG_NS  = 40 * FRAME_CLKS * CLK_PERIOD + 2000;

	logic       clk;
	logic       i_reset;
	logic       i_uart_rx;
	logic [3:0] i_sw;
	logic       o_uart_tx;
	logic [3:0] o_led;

	logic       reset_done;
	logic [3:0] led_model;
	logic [7:0] rx_q[$];
	logic [7:0] exp_q[$];

	uart_ctl_sys #(.CLK_PERIOD(CLK_PERIOD), .UART_BAUD(UART_BAUD)) dut_i (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_uart_rx (i_uart_rx),
		.i_sw      (i_sw),
		.o_uart_tx (o_uart_tx),
		.o_led     (o_led)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_failure();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	// All driving tasks start and end 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic send_byte(input logic [7:0] data, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			i_uart_rx = frame[i];
			wait_cycles(CLKS_PER_BIT);
		end
	endtask

	// Host receiver sampling the reply line at mid-bit on falling clock edges
	task automatic recv_byte(output logic [7:0] data);
		while (o_uart_tx !== 1'b0)
			@(negedge clk);
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		if (o_uart_tx !== 1'b0) begin
			$display("Reply start bit did not hold low until mid-bit");
			stop_on_failure();
		end else begin
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				data[i] = o_uart_tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			if (o_uart_tx !== 1'b1) begin
				$display("Reply stop bit was low");
				stop_on_failure();
			end
		end
	endtask

	function automatic uart_ctl_pkg::cmd_byte_t make_cmd(input uart_ctl_pkg::cmd_op_e op,
			input logic [3:0] arg);
		uart_ctl_pkg::cmd_byte_t c;
		c.op   = op;
		c.rsvd = 2'b00;
		c.arg  = arg;
		return c;
	endfunction

	// Bit 8 is set when the command answers and bits 7:0 then hold the reply
	function automatic logic [8:0] ref_reply(input uart_ctl_pkg::cmd_byte_t cmd,
			input logic [3:0] led, input logic [3:0] sw);
		case (cmd.op)
			uart_ctl_pkg::OP_SET_LED: ref_reply = 9'h000;
			uart_ctl_pkg::OP_GET_SW:  ref_reply = {1'b1, uart_ctl_pkg::REPLY_SW, sw};
			uart_ctl_pkg::OP_GET_LED: ref_reply = {1'b1, uart_ctl_pkg::REPLY_LED, led};
			default:                  ref_reply = {1'b1, uart_ctl_pkg::REPLY_ERR};
		endcase
	endfunction

	task automatic expect_reply(input string name, input logic [7:0] expected);
		int waited;
		logic [7:0] got;
		waited = 0;
		while (rx_q.size() == 0 && waited < 2 * FRAME_CLKS) begin
			wait_cycles(1);
			waited++;
		end
		if (rx_q.size() == 0) begin
			$display("Test %s: no reply arrived within two frame times", name);
			stop_on_failure();
		end else begin
			got = rx_q.pop_front();
			check_value(name, expected, got);
		end
	endtask

	task automatic check_line_idle(input string name, input int cycles);
		repeat (cycles) begin
			check_value(name, 8'h01, {7'd0, o_uart_tx});
			wait_cycles(1);
		end
	endtask

	// Compares every reply that has arrived against the oldest expected one
	task automatic drain_replies(input string name);
		logic [7:0] got;
		logic [7:0] want;
		while (rx_q.size() > 0) begin
			got = rx_q.pop_front();
			if (exp_q.size() == 0) begin
				$display("Test %s: reply %h arrived with no command waiting for it", name, got);
				stop_on_failure();
			end else begin
				want = exp_q.pop_front();
				check_value(name, want, got);
			end
		end
	endtask

	task automatic reset_state();
		check_value("reset led", 8'h00, {4'h0, o_led});
		check_line_idle("reset tx line", 100);
	endtask

	task automatic led_write_readback();
		send_byte(make_cmd(uart_ctl_pkg::OP_SET_LED, 4'hA), 1'b1);
		led_model = 4'hA;
		check_value("led write", 8'h0A, {4'h0, o_led});
		send_byte(make_cmd(uart_ctl_pkg::OP_GET_LED, 4'h0), 1'b1);
		expect_reply("led readback", 8'hAA);
	endtask

	task automatic switch_readback();
		uart_ctl_pkg::cmd_byte_t cmd;
		logic [8:0] r;
		i_sw = 4'($urandom);
		wait_cycles(10);
		cmd = make_cmd(uart_ctl_pkg::OP_GET_SW, 4'h0);
		r   = ref_reply(cmd, led_model, i_sw);
		send_byte(cmd, 1'b1);
		expect_reply("switch readback", r[7:0]);
	endtask

	task automatic bad_opcode_reply();
		uart_ctl_pkg::cmd_byte_t cmd;
		logic [8:0] r;
		cmd = make_cmd(uart_ctl_pkg::OP_BAD, ~led_model);
		r   = ref_reply(cmd, led_model, i_sw);
		send_byte(cmd, 1'b1);
		expect_reply("bad opcode reply", r[7:0]);
		check_value("bad opcode led", {4'h0, led_model}, {4'h0, o_led});
	endtask

	task automatic framing_error_drop();
		logic [8:0] r;
		// A set-LED byte that would change the LEDs if it were accepted
		send_byte(make_cmd(uart_ctl_pkg::OP_SET_LED, ~led_model), 1'b0);
		i_uart_rx = 1'b1;
		check_line_idle("framing error tx line", FRAME_CLKS);
		check_value("framing error reply count", 8'h00, 8'(rx_q.size()));
		check_value("framing error led", {4'h0, led_model}, {4'h0, o_led});
		r = ref_reply(make_cmd(uart_ctl_pkg::OP_GET_LED, 4'h0), led_model, i_sw);
		send_byte(make_cmd(uart_ctl_pkg::OP_GET_LED, 4'h0), 1'b1);
		expect_reply("led readback after framing error", r[7:0]);
	endtask

	task automatic random_sequence();
		uart_ctl_pkg::cmd_byte_t cmd;
		logic [8:0] r;
		int waited;
		for (int k = 0; k < 20; k++) begin
			i_sw = 4'($urandom);
			cmd  = uart_ctl_pkg::cmd_byte_t'(8'($urandom));
			r    = ref_reply(cmd, led_model, i_sw);
			send_byte(cmd, 1'b1);
			if (r[8]) begin
				exp_q.push_back(r[7:0]);
			end else begin
				led_model = cmd.arg;
				check_value("random led", {4'h0, led_model}, {4'h0, o_led});
			end
			drain_replies("random reply");
		end
		waited = 0;
		while (exp_q.size() > 0 && waited < 2 * FRAME_CLKS) begin
			wait_cycles(1);
			waited++;
			drain_replies("random reply");
		end
		check_value("random replies missing", 8'h00, 8'(exp_q.size()));
	endtask

	initial begin : reply_monitor
		logic [7:0] b;
		wait (reset_done);
		forever begin
			recv_byte(b);
			rx_q.push_back(b);
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		stop_on_failure();
	end

	initial begin
		clk        = 1'b0;
		i_reset    = 1'b1;
		i_uart_rx  = 1'b1;
		i_sw       = 4'h0;
		reset_done = 1'b0;
		led_model  = 4'h0;
		void'($urandom(9));
		wait_cycles(4);
		i_reset    = 1'b0;
		reset_done = 1'b1;
		reset_state();
		led_write_readback();
		switch_readback();
		bad_opcode_reply();
		framing_error_drop();
		random_sequence();
		$display("Simulation passed");
		$finish;
	end

endmodule
